// ==== design/cen_frac.sv ====
////////////////////
// Fractional clock enable, one pulse every lim/step clocks on average
// Set step and lim per instance, cen is a single cycle strobe
////////////////////

module cen_frac #(
    parameter logic [pcm_timing_pkg::CEN_W-1:0] step = pcm_timing_pkg::CEN_W'(1),
    parameter logic [pcm_timing_pkg::CEN_W-1:0] lim  = pcm_timing_pkg::CEN_W'(2)
) (
    input  logic clk,
    input  logic rst,
    output logic cen
);

    logic [pcm_timing_pkg::CEN_W-1:0] cnt;     // Modulo accumulator
    logic [pcm_timing_pkg::CEN_W:0]   nxt;     // One extra bit so the sum cannot wrap
    logic [pcm_timing_pkg::CEN_W:0]   nxt_sub;
    logic [pcm_timing_pkg::CEN_W:0]   absmax;  // Never reached in normal counting
    logic                             bad_cnt;

    always_comb begin
        nxt     = {1'b0, cnt} + {1'b0, step};
        nxt_sub = nxt - {1'b0, lim};
        absmax  = {1'b0, lim} + {1'b0, step};
        bad_cnt = {1'b0, cnt} >= absmax;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            cen <= 1'b0;
        end else if (bad_cnt) begin
            // Out of range count, start over
            cnt <= '0;
            cen <= 1'b1;
        end else if (nxt >= {1'b0, lim}) begin
            cnt <= nxt_sub[pcm_timing_pkg::CEN_W-1:0];  // Keep the remainder
            cen <= 1'b1;
        end else begin
            cnt <= nxt[pcm_timing_pkg::CEN_W-1:0];
            cen <= 1'b0;
        end
    end

endmodule

// ==== design/pcm_bus_pkg.sv ====
////////////////////
// Widths of the sample ROM bus, the samples, volumes and the mixed output
////////////////////

package pcm_bus_pkg;

    ////////////////////
    // ROM port
    ////////////////////

    localparam int ROM_AW = 16;     // Sample ROM address
    localparam int ROM_DW = 8;      // One signed sample per byte

    localparam int NCH = 2;         // Channels sharing the ROM

    ////////////////////
    // Mixer
    ////////////////////

    localparam int VOL_W    = 4;    // Unsigned volume
    localparam int VOL_FRAC = 3;    // Volume 8 is unity gain
    localparam int MIX_W    = 16;   // Signed output

    // Sample byte lands in the top of the output word at unity gain
    localparam int MIX_SH = MIX_W - ROM_DW - VOL_FRAC;

    // Headroom for two scaled products before the clamp
    localparam int SUM_W = MIX_W + VOL_W + 1;

    localparam int MIX_MAX = 2**(MIX_W-1) - 1;
    localparam int MIX_MIN = -(2**(MIX_W-1));

endpackage

// ==== design/pcm_channel.sv ====
////////////////////
// One PCM channel, fetches a sample per enable from first to last address
// Holds the latest sample for the mixer until the next fetch lands
////////////////////

module pcm_channel (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cen,        // Sample rate strobe
    input  logic                                   start,      // Begin playback
    input  logic        [pcm_bus_pkg::ROM_AW-1:0]  addr_first,
    input  logic        [pcm_bus_pkg::ROM_AW-1:0]  addr_last,
    input  logic                                   gnt_ok,     // Fetch done, data valid
    input  logic        [pcm_bus_pkg::ROM_DW-1:0]  data,
    output logic                                   req,        // Fetch pending
    output logic        [pcm_bus_pkg::ROM_AW-1:0]  addr,       // Current fetch address
    output logic signed [pcm_bus_pkg::ROM_DW-1:0]  sample,     // Hold sample
    output logic                                   busy,
    output logic                                   done
);

    logic [pcm_bus_pkg::ROM_AW-1:0] last_q;    // End of range, latched at start
    logic                           at_last;
    logic                           fetch;

    assign at_last = addr == last_q;

    // Enables arriving with a fetch still out are lost, not queued
    assign fetch = cen && busy && !req;

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            req  <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;                   // Single cycle pulse
            if (start) begin
                busy <= 1'b1;
                req  <= 1'b0;
            end else if (req && gnt_ok) begin
                req <= 1'b0;
                if (at_last) begin
                    busy <= 1'b0;           // Falls with done
                    done <= 1'b1;
                end
            end else if (fetch) begin
                req <= 1'b1;
            end
        end
    end

    ////////////////////
    // Address walk
    ////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            addr   <= addr_first;
            last_q <= addr_last;
        end else if (req && gnt_ok && !at_last) begin
            addr <= addr + 1'b1;            // Next byte of the range
        end
    end

    ////////////////////
    // Hold sample
    ////////////////////

    // Cleared so the mixer never sees stale data from a previous run
    always_ff @(posedge clk) begin
        if (rst) begin
            sample <= '0;
        end else if (start) begin
            sample <= '0;
        end else if (req && gnt_ok) begin
            sample <= signed'(data);        // Visible the cycle after gnt_ok
        end
    end

endmodule

// ==== design/pcm_mixer.sv ====
////////////////////
// Two channel mixer with 4-bit volumes, saturating to a signed 16-bit output
// Updates on its own enable and flags each new output word
////////////////////

module pcm_mixer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cen,      // Mixer rate strobe
    input  logic signed [pcm_bus_pkg::ROM_DW-1:0]  s0,
    input  logic signed [pcm_bus_pkg::ROM_DW-1:0]  s1,
    input  logic        [pcm_bus_pkg::VOL_W-1:0]   vol0,     // Gain in eighths
    input  logic        [pcm_bus_pkg::VOL_W-1:0]   vol1,
    output logic signed [pcm_bus_pkg::MIX_W-1:0]   snd,
    output logic                                   snd_sample
);

    logic signed [pcm_bus_pkg::SUM_W-1:0] p0;    // Scaled channel 0
    logic signed [pcm_bus_pkg::SUM_W-1:0] p1;    // Scaled channel 1
    logic signed [pcm_bus_pkg::SUM_W-1:0] sum;
    logic signed [pcm_bus_pkg::MIX_W-1:0] sat;

    ////////////////////
    // Scale and sum
    ////////////////////

    always_comb begin
        // Volume zero extended so the product stays signed
        p0  = (s0 * signed'({1'b0, vol0})) <<< pcm_bus_pkg::MIX_SH;
        p1  = (s1 * signed'({1'b0, vol1})) <<< pcm_bus_pkg::MIX_SH;
        sum = p0 + p1;
        if (sum > pcm_bus_pkg::MIX_MAX) begin
            sat = pcm_bus_pkg::MIX_W'(pcm_bus_pkg::MIX_MAX);     // Clip high
        end else if (sum < pcm_bus_pkg::MIX_MIN) begin
            sat = pcm_bus_pkg::MIX_W'(pcm_bus_pkg::MIX_MIN);     // Clip low
        end else begin
            sat = sum[pcm_bus_pkg::MIX_W-1:0];
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            snd        <= '0;
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= cen;          // Marks the cycle snd changes
            if (cen) begin
                snd <= sat;
            end
        end
    end

endmodule

// ==== design/pcm_player_top.sv ====
////////////////////
// Two channel PCM player on a shared sample ROM, 48 MHz system clock
// Start each channel with an address range and a volume, snd carries the mix
////////////////////

module pcm_player_top (
    input  logic                                   clk,
    input  logic                                   rst,
    // Channel 0 control
    input  logic                                   ch0_start,
    input  logic        [pcm_bus_pkg::ROM_AW-1:0]  ch0_addr_first,
    input  logic        [pcm_bus_pkg::ROM_AW-1:0]  ch0_addr_last,
    input  logic        [pcm_bus_pkg::VOL_W-1:0]   ch0_vol,
    output logic                                   ch0_busy,
    output logic                                   ch0_done,
    // Channel 1 control
    input  logic                                   ch1_start,
    input  logic        [pcm_bus_pkg::ROM_AW-1:0]  ch1_addr_first,
    input  logic        [pcm_bus_pkg::ROM_AW-1:0]  ch1_addr_last,
    input  logic        [pcm_bus_pkg::VOL_W-1:0]   ch1_vol,
    output logic                                   ch1_busy,
    output logic                                   ch1_done,
    // Sample ROM
    output logic        [pcm_bus_pkg::ROM_AW-1:0]  rom_addr,
    output logic                                   rom_cs,
    input  logic        [pcm_bus_pkg::ROM_DW-1:0]  rom_data,
    input  logic                                   rom_ok,
    // Sound out
    output logic signed [pcm_bus_pkg::MIX_W-1:0]   snd,
    output logic                                   snd_sample
);

    logic                                  cen_ch0;
    logic                                  cen_ch1;
    logic                                  cen_mix;
    logic        [pcm_bus_pkg::NCH-1:0]    req;         // Fetch requests
    logic        [pcm_bus_pkg::NCH-1:0]    gnt_ok;
    logic        [pcm_bus_pkg::ROM_AW-1:0] ch0_addr;
    logic        [pcm_bus_pkg::ROM_AW-1:0] ch1_addr;
    logic        [pcm_bus_pkg::ROM_DW-1:0] rom_q;       // Data back to channels
    logic signed [pcm_bus_pkg::ROM_DW-1:0] ch0_sample;
    logic signed [pcm_bus_pkg::ROM_DW-1:0] ch1_sample;

    ////////////////////
    // Rate generators
    ////////////////////

    cen_frac #(.step(pcm_timing_pkg::CH0_STEP), .lim(pcm_timing_pkg::CH0_LIM)) i_cen_ch0 (
        .clk(clk), .rst(rst), .cen(cen_ch0)
    );

    cen_frac #(.step(pcm_timing_pkg::CH1_STEP), .lim(pcm_timing_pkg::CH1_LIM)) i_cen_ch1 (
        .clk(clk), .rst(rst), .cen(cen_ch1)
    );

    cen_frac #(.step(pcm_timing_pkg::MIX_STEP), .lim(pcm_timing_pkg::MIX_LIM)) i_cen_mix (
        .clk(clk), .rst(rst), .cen(cen_mix)
    );

    ////////////////////
    // Channels
    ////////////////////

    pcm_channel i_ch0 (
        .clk(clk), .rst(rst), .cen(cen_ch0), .start(ch0_start),
        .addr_first(ch0_addr_first), .addr_last(ch0_addr_last),
        .gnt_ok(gnt_ok[0]), .data(rom_q), .req(req[0]), .addr(ch0_addr),
        .sample(ch0_sample), .busy(ch0_busy), .done(ch0_done)
    );

    pcm_channel i_ch1 (
        .clk(clk), .rst(rst), .cen(cen_ch1), .start(ch1_start),
        .addr_first(ch1_addr_first), .addr_last(ch1_addr_last),
        .gnt_ok(gnt_ok[1]), .data(rom_q), .req(req[1]), .addr(ch1_addr),
        .sample(ch1_sample), .busy(ch1_busy), .done(ch1_done)
    );

    ////////////////////
    // ROM sharing and mix
    ////////////////////

    rom_arbiter i_arb (
        .clk(clk), .rst(rst), .req(req), .addr0(ch0_addr), .addr1(ch1_addr),
        .rom_data(rom_data), .rom_ok(rom_ok), .gnt_ok(gnt_ok),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .data(rom_q)
    );

    pcm_mixer i_mix (
        .clk(clk), .rst(rst), .cen(cen_mix), .s0(ch0_sample), .s1(ch1_sample),
        .vol0(ch0_vol), .vol1(ch1_vol), .snd(snd), .snd_sample(snd_sample)
    );

endmodule

// ==== design/pcm_timing_pkg.sv ====
////////////////////
// Clock enable rates for the PCM player, all derived from the 48 MHz system clock
// Each rate is a step and limit pair for a fractional accumulator
////////////////////

package pcm_timing_pkg;

    // Accumulator, step and limit width
    localparam int CEN_W = 16;

    ////////////////////
    // Channel rates
    ////////////////////

    localparam logic [CEN_W-1:0] CH0_STEP = CEN_W'(1);      // 48 MHz / 125 = 384 kHz
    localparam logic [CEN_W-1:0] CH0_LIM  = CEN_W'(125);

    localparam logic [CEN_W-1:0] CH1_STEP = CEN_W'(1);      // 48 MHz / 96 = 500 kHz
    localparam logic [CEN_W-1:0] CH1_LIM  = CEN_W'(96);

    // Mixer rate, close to the 3.579545 MHz NTSC colour burst
    localparam logic [CEN_W-1:0] MIX_STEP = CEN_W'(3758);
    localparam logic [CEN_W-1:0] MIX_LIM  = CEN_W'(50393);

endpackage

// ==== design/rom_arbiter.sv ====
////////////////////
// Shares the sample ROM port between the two channels
// Serves one fetch at a time, round robin on ties
////////////////////

module rom_arbiter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [pcm_bus_pkg::NCH-1:0]     req,
    input  logic [pcm_bus_pkg::ROM_AW-1:0]  addr0,
    input  logic [pcm_bus_pkg::ROM_AW-1:0]  addr1,
    input  logic [pcm_bus_pkg::ROM_DW-1:0]  rom_data,
    input  logic                            rom_ok,     // ROM answer strobe
    output logic [pcm_bus_pkg::NCH-1:0]     gnt_ok,     // Per channel completion
    output logic [pcm_bus_pkg::ROM_AW-1:0]  rom_addr,
    output logic                            rom_cs,
    output logic [pcm_bus_pkg::ROM_DW-1:0]  data        // Shared return bus
);

    logic owner;        // Channel holding the ROM
    logic last;         // Channel served most recently
    logic win;          // Arbitration result for an idle port
    logic fin;

    ////////////////////
    // Round robin choice
    ////////////////////

    always_comb begin
        case (req)
            2'b01:   win = 1'b0;
            2'b10:   win = 1'b1;
            2'b11:   win = ~last;       // Tie goes to the other peer
            default: win = last;
        endcase
    end

    assign fin = rom_cs && rom_ok;

    ////////////////////
    // ROM port
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rom_cs <= 1'b0;
            owner  <= 1'b0;
            last   <= 1'b1;             // Channel 0 wins the first tie
        end else if (!rom_cs) begin
            if (|req) begin
                rom_cs <= 1'b1;
                owner  <= win;
            end
        end else if (rom_ok) begin
            rom_cs <= 1'b0;
            last   <= owner;
        end
    end

    // Address only loads while idle, held steady during the access
    always_ff @(posedge clk) begin
        if (!rom_cs && |req) begin
            rom_addr <= win ? addr1 : addr0;
        end
    end

    ////////////////////
    // Return path
    ////////////////////

    assign gnt_ok[0] = fin && !owner;
    assign gnt_ok[1] = fin && owner;
    assign data      = rom_data;    // Valid only with gnt_ok

endmodule

// ==== pcm_player.f ====
design/pcm_timing_pkg.sv
design/pcm_bus_pkg.sv
design/cen_frac.sv
design/pcm_channel.sv
design/rom_arbiter.sv
design/pcm_mixer.sv
design/pcm_player_top.sv
test/pcm_player_checker.sv
test/pcm_player_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the PCM player testbench with Verilator, runs it and looks for the pass line in sim.log

cd "$(dirname "$0")" || exit 1

rm -f sim.log \
    && verilator --binary --timing --assert -Wno-fatal \
        -f pcm_player.f --top-module pcm_player_tb -o pcm_player_sim \
    && { ./obj_dir/pcm_player_sim > sim.log 2>&1 || true; } \
    && grep -qx "Test OK" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== test/pcm_player_checker.sv ====
////////////////////
// Protocol assertions on the sample ROM port and the channel status
// Bound into every pcm_player_top instance
////////////////////

module pcm_player_checker (
    input logic                           clk,
    input logic                           rst,
    input logic [pcm_bus_pkg::ROM_AW-1:0] rom_addr,
    input logic                           rom_cs,
    input logic                           rom_ok,
    input logic                           ch0_busy,
    input logic                           ch0_done,
    input logic                           ch1_busy,
    input logic                           ch1_done
);

    ////////////////////
    // ROM port
    ////////////////////

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> $stable(rom_addr))
        else $error("rom_addr changed while the access waited for rom_ok");

    cs_held: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs)     // No abandoned access
        else $error("rom_cs dropped before rom_ok");

    // Port and channels idle out of reset
    idle_after_rst: assert property (@(posedge clk)
        rst |=> !rom_cs && !ch0_busy && !ch1_busy)
        else $error("rom_cs or a busy flag high right after reset");

    ////////////////////
    // Channel status
    ////////////////////

    ch0_done_ends_busy: assert property (@(posedge clk) disable iff (rst)
        ch0_done |-> $fell(ch0_busy))
        else $error("channel 0 done without busy falling");

    ch1_done_ends_busy: assert property (@(posedge clk) disable iff (rst)
        ch1_done |-> $fell(ch1_busy))
        else $error("channel 1 done without busy falling");

endmodule

bind pcm_player_top pcm_player_checker i_checker (
    .clk(clk), .rst(rst), .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_ok(rom_ok),
    .ch0_busy(ch0_busy), .ch0_done(ch0_done), .ch1_busy(ch1_busy), .ch1_done(ch1_done)
);

// ==== test/pcm_player_tb.sv ====
////////////////////
// Testbench for the two channel PCM player with a random latency sample ROM
// Runs the tests in order while every mixer output is checked against a model
////////////////////

module pcm_player_tb;

    localparam int AW         = pcm_bus_pkg::ROM_AW;
    localparam int DW         = pcm_bus_pkg::ROM_DW;
    localparam int CH0_PERIOD = int'(pcm_timing_pkg::CH0_LIM) / int'(pcm_timing_pkg::CH0_STEP);
    localparam int CH1_PERIOD = int'(pcm_timing_pkg::CH1_LIM) / int'(pcm_timing_pkg::CH1_STEP);
    localparam int RATE_STEP  = int'(pcm_timing_pkg::MIX_STEP);
    localparam int RATE_LIM   = int'(pcm_timing_pkg::MIX_LIM);
    localparam int WINDOW     = 4000;                  // Mixer rate window
    localparam int TIMEOUT_CYCLES = 20000;             // About twice the summed test lengths

    logic                                 clk;
    logic                                 rst;
    logic                                 ch0_start;
    logic                                 ch1_start;
    logic        [AW-1:0]                 ch0_addr_first;
    logic        [AW-1:0]                 ch0_addr_last;
    logic        [AW-1:0]                 ch1_addr_first;
    logic        [AW-1:0]                 ch1_addr_last;
    logic        [pcm_bus_pkg::VOL_W-1:0] ch0_vol;
    logic        [pcm_bus_pkg::VOL_W-1:0] ch1_vol;
    logic                                 ch0_busy;
    logic                                 ch0_done;
    logic                                 ch1_busy;
    logic                                 ch1_done;
    logic        [AW-1:0]                 rom_addr;
    logic                                 rom_cs;
    logic        [DW-1:0]                 rom_data;
    logic                                 rom_ok;
    logic signed [pcm_bus_pkg::MIX_W-1:0] snd;
    logic                                 snd_sample;

    logic signed [DW-1:0]                 hold0;       // Model hold samples
    logic signed [DW-1:0]                 hold1;
    logic signed [pcm_bus_pkg::MIX_W-1:0] exp_snd;     // Due at the next snd_sample
    logic        [AW-1:0]                 r0_first = '1;   // Empty until a start
    logic        [AW-1:0]                 r0_last  = '0;
    logic        [AW-1:0]                 r1_first = '1;
    logic        [AW-1:0]                 r1_last  = '0;
    logic        [AW-1:0]                 fetch_q[$];  // ROM addresses in service order
    string                                test_name = "idle";
    int unsigned                          lcg_state;
    int  rom_wait  = 0;
    int  slow_lat  = 0;                                // Nonzero forces the ROM latency
    int  cyc       = 0;
    int  snd_n     = 0;
    int  done0_n   = 0;
    int  done1_n   = 0;
    int  done0_at  = 0;
    int  done1_at  = 0;
    int  start0_at = 0;
    int  start1_at = 0;
    int  snd_base;
    int  rate_err;

    pcm_player_top i_pcm_player_top (.*);

    always #20 clk = ~clk;

    ////////////////////
    // Reference and helpers
    ////////////////////

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Extreme bytes at both ends of each 16 byte block
    function automatic logic [DW-1:0] rom_byte(input logic [AW-1:0] a);
        if (a[3:0] == 4'hf) begin
            return 8'h7f;
        end
        if (a[3:0] == 4'h0) begin
            return 8'h80;
        end
        return (a[7:0] * 8'd29) ^ a[15:8];
    endfunction

    // Volume in eighths, byte at the top of the output word, clamp to 16 bits
    function automatic logic signed [15:0] ref_mix(input logic signed [DW-1:0] s0,
                                                   input logic signed [DW-1:0] s1,
                                                   input logic [3:0] v0,
                                                   input logic [3:0] v1);
        int sum;
        sum = (int'(s0) * int'(v0) + int'(s1) * int'(v1)) * 256 / 8;
        if (sum > 32767) begin
            sum = 32767;
        end else if (sum < -32768) begin
            sum = -32768;
        end
        return 16'(sum);
    endfunction

    task automatic check(input string name, input logic signed [31:0] expected,
                         input logic signed [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic start_ch(input int ch, input logic [AW-1:0] first,
                            input logic [AW-1:0] last, input logic [3:0] vol);
        @(posedge clk);
        if (ch == 0) begin
            ch0_addr_first <= first;
            ch0_addr_last  <= last;
            ch0_vol        <= vol;
            ch0_start      <= 1'b1;
            r0_first  = first;
            r0_last   = last;
            start0_at = cyc;
        end else begin
            ch1_addr_first <= first;
            ch1_addr_last  <= last;
            ch1_vol        <= vol;
            ch1_start      <= 1'b1;
            r1_first  = first;
            r1_last   = last;
            start1_at = cyc;
        end
        @(posedge clk);
        ch0_start <= 1'b0;                             // One cycle pulse
        ch1_start <= 1'b0;
    endtask

    task automatic wait_done(input int ch, input int target);
        while ((ch == 0 ? done0_n : done1_n) < target) begin
            @(posedge clk);
        end
    endtask

    task automatic check_order(input logic [AW-1:0] first, input int len);
        check({test_name, " fetch count"}, len, fetch_q.size());
        foreach (fetch_q[i]) begin
            check({test_name, " fetch order"}, first + i, fetch_q[i]);
        end
    endtask

    task automatic check_each_once(input logic [AW-1:0] first, input int len);
        int n;
        for (int k = 0; k < len; k++) begin
            n = 0;
            foreach (fetch_q[i]) begin
                n += int'(fetch_q[i] == first + k);
            end
            check({test_name, " fetches per address"}, 1, n);
        end
    endtask

    ////////////////////
    // ROM model
    ////////////////////

    always @(posedge clk) begin
        if (rst) begin
            rom_ok <= 1'b0;
            rom_wait = 0;
        end else begin
            rom_ok <= 1'b0;
            if (rom_wait > 0) begin
                rom_wait = rom_wait - 1;
                if (rom_wait == 0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_byte(rom_addr);
                end
            end else if (rom_cs && !rom_ok) begin   // New access
                lcg_state = lcg_next(lcg_state);
                rom_wait  = (slow_lat > 0) ? slow_lat : 1 + int'((lcg_state >> 16) % 6);
            end
        end
    end

    ////////////////////
    // Model and compare
    ////////////////////

    always @(negedge clk) begin
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "cycle limit reached");
        end else if (rst) begin
            hold0   = '0;
            hold1   = '0;
            exp_snd = '0;
        end else begin
            if (snd_sample) begin
                snd_n = snd_n + 1;
                check(test_name, exp_snd, snd);
            end
            exp_snd = ref_mix(hold0, hold1, ch0_vol, ch1_vol);  // Holds of this cycle
            if (rom_cs && rom_ok) begin
                fetch_q.push_back(rom_addr);
                if (rom_addr >= r0_first && rom_addr <= r0_last) begin
                    hold0 = rom_byte(rom_addr);
                end else if (rom_addr >= r1_first && rom_addr <= r1_last) begin
                    hold1 = rom_byte(rom_addr);
                end
            end
            if (ch0_start) begin
                hold0 = '0;
            end
            if (ch1_start) begin
                hold1 = '0;
            end
            if (ch0_done) begin
                done0_n  = done0_n + 1;
                done0_at = cyc;
            end
            if (ch1_done) begin
                done1_n  = done1_n + 1;
                done1_at = cyc;
            end
        end
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        ch0_start      = 1'b0;
        ch1_start      = 1'b0;
        ch0_addr_first = '0;
        ch0_addr_last  = '0;
        ch1_addr_first = '0;
        ch1_addr_last  = '0;
        ch0_vol        = '0;
        ch1_vol        = '0;
        rom_data       = '0;
        rom_ok         = 1'b0;
        lcg_state      = 16300;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Quiet until the first start, first mixer enable comes later
        test_name = "reset";
        repeat (10) begin
            @(negedge clk);
            check("reset snd", 0, snd);
            check("reset busy or done", 0, {ch0_busy, ch0_done, ch1_busy, ch1_done});
            check("reset rom_cs", 0, rom_cs);
            check("reset snd_sample", 0, snd_sample);
        end

        test_name = "ch0 alone";
        fetch_q.delete();
        start_ch(0, 16'h0100, 16'h010f, 4'd8);
        wait_done(0, 1);
        check_order(16'h0100, 16);
        repeat (2 * CH0_PERIOD) begin
            @(negedge clk);
            check({test_name, " busy after done"}, 0, ch0_busy);
        end
        @(posedge clk);
        check({test_name, " done pulses"}, 1, done0_n);

        // Overlapping runs, full volume drives the mix into saturation
        test_name = "both channels";
        fetch_q.delete();
        start_ch(0, 16'h2000, 16'h200f, 4'd15);
        repeat (37) @(posedge clk);
        start_ch(1, 16'h3040, 16'h3053, 4'd15);
        repeat (500) @(posedge clk);
        ch1_vol <= 4'd9;
        wait_done(0, 2);
        wait_done(1, 1);
        check({test_name, " fetch count"}, 36, fetch_q.size());
        check_each_once(16'h2000, 16);
        check_each_once(16'h3040, 20);
        check({test_name, " ch0 finish time"}, 1,
              done0_at - start0_at <= CH0_PERIOD * 16 * 11 / 10);
        check({test_name, " ch1 finish time"}, 1,
              done1_at - start1_at <= CH1_PERIOD * 20 * 11 / 10);

        test_name = "mixer rate";
        snd_base = snd_n;
        repeat (WINDOW) @(posedge clk);
        rate_err = (snd_n - snd_base) * RATE_LIM - WINDOW * RATE_STEP;
        check({test_name, " pulses within one"}, 1, rate_err <= RATE_LIM && rate_err >= -RATE_LIM);

        // ROM slower than the channel period, late enables are lost
        test_name = "slow rom";
        fetch_q.delete();
        slow_lat = CH0_PERIOD + 30;
        start_ch(0, 16'h4088, 16'h408f, 4'd5);
        wait_done(0, 3);
        slow_lat = 0;
        check_order(16'h4088, 8);
        check({test_name, " enables dropped"}, 1, done0_at - start0_at > 14 * CH0_PERIOD);

        $display("Test OK");
        $finish;
    end

endmodule
